// File: hw/sha256_defines.svh
`ifndef SHA256_DEFINES_SVH
`define SHA256_DEFINES_SVH

// Width of one message or state word
`define SHA_WORD_W 32

// A 512-bit block arrives as this many words
`define SHA_BLOCK_WORDS 16

`define SHA_STAGE_ROUNDS 16 // Rounds handled by one pipeline stage
`define SHA_NUM_STAGES 4    // Stages needed to cover all 64 rounds

// Must hold the values 0 to SHA_STAGE_ROUNDS-1
`define SHA_CNT_W 4

`endif

// File: hw/sha256_types_pkg.sv
`include "sha256_defines.svh"

package sha256_types_pkg;

    // One message or state word
    typedef logic [`SHA_WORD_W-1:0] word_t;

    // Working variables a to h, with a at index 0 in the top bits
    // The digest uses the same layout, H0 first
    typedef word_t [0:7] state_t;

    // Schedule window, index 0 holds the newest word
    typedef word_t [`SHA_BLOCK_WORDS-1:0] window_t;

    typedef logic [`SHA_CNT_W-1:0] round_cnt_t; // Round position inside a stage

endpackage

// File: hw/sha256_algo_pkg.sv
`include "sha256_defines.svh"

package sha256_algo_pkg;

    import sha256_types_pkg::*;

    // Round constants for all 64 rounds
    parameter word_t K_TABLE [0:`SHA_NUM_STAGES*`SHA_STAGE_ROUNDS-1] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Standard initial hash value, H0 in the top word
    parameter state_t H_INIT = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    function automatic word_t rotr(word_t x, int unsigned n);
        return (x >> n) | (x << (`SHA_WORD_W - n));
    endfunction

    function automatic word_t big_sigma0(word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sigma1(word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    // Schedule expansion terms
    function automatic word_t small_sigma0(word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    function automatic word_t ch(word_t e, word_t f, word_t g);
        return (e & f) ^ (~e & g);
    endfunction

    function automatic word_t maj(word_t a, word_t b, word_t c);
        return (a & b) ^ (a & c) ^ (b & c);
    endfunction

    // Constant for round cnt of the given stage, stage 0 covers rounds 0 to 15
    function automatic word_t round_k(int unsigned stage, round_cnt_t cnt);
        return K_TABLE[stage * `SHA_STAGE_ROUNDS + int'(cnt)];
    endfunction

endpackage

// File: hw/sha256_round.sv
`timescale 1ns/1ps

module sha256_round import sha256_types_pkg::*, sha256_algo_pkg::*;
(
    input  state_t state,
    input  word_t  w,
    input  word_t  k,
    output state_t next_state
);

    word_t t1;
    word_t t2;

    // state[0] is a, state[7] is h
    assign t1 = state[7] + big_sigma1(state[4]) + ch(state[4], state[5], state[6]) + k + w;
    assign t2 = big_sigma0(state[0]) + maj(state[0], state[1], state[2]);

    always_comb
    begin
        next_state[0] = t1 + t2;
        next_state[1] = state[0];
        next_state[2] = state[1];
        next_state[3] = state[2];
        next_state[4] = state[3] + t1; // New e picks up d
        next_state[5] = state[4];
        next_state[6] = state[5];
        next_state[7] = state[6];
    end

endmodule

// File: hw/msg_schedule.sv
`timescale 1ns/1ps

`include "sha256_defines.svh"

module msg_schedule import sha256_types_pkg::*, sha256_algo_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    load,
    input  window_t window_in,
    input  logic    advance,
    output word_t   w_next,
    output window_t window
);

    window_t window_q;

    // With index 0 as W[t-1], these positions are W[t-2], W[t-7], W[t-15] and W[t-16]
    assign w_next = small_sigma1(window_q[1]) + window_q[6]
                  + small_sigma0(window_q[14]) + window_q[15];

    assign window = window_q;

    always_ff @(posedge clk)
    begin
        if (load)
            window_q <= window_in;
        else if (advance)
            window_q <= {window_q[`SHA_BLOCK_WORDS-2:0], w_next}; // Oldest word drops out
    end

    // The owning stage finishes its last round without shifting, so a new block
    // may load on that edge and the two requests never meet
    load_advance_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && advance)
    )
    else $error("Schedule window asked to load and advance together");

endmodule

// File: hw/intake_stage.sv
`timescale 1ns/1ps

`include "sha256_defines.svh"

module intake_stage import sha256_types_pkg::*, sha256_algo_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    word_valid,
    input  word_t   word,
    output logic    done,
    output state_t  state_out,
    output window_t window_out
);

    round_cnt_t cnt;
    state_t     state_q;
    state_t     round_in;
    state_t     round_out;
    window_t    window_q;
    word_t      k;
    logic       last_word;

    assign last_word = (cnt == round_cnt_t'(`SHA_STAGE_ROUNDS - 1));

    // Word 0 starts a fresh block from the initial hash value
    assign round_in = (cnt == '0) ? H_INIT : state_q;
    assign k        = round_k(0, cnt);

    sha256_round round_i (
        .state      (round_in),
        .w          (word),
        .k          (k),
        .next_state (round_out)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= word_valid && last_word;
            if (word_valid)
                cnt <= cnt + round_cnt_t'(1); // Wraps back to 0 after word 15
        end
    end

    // The next block can overwrite these on the edge after done, which is
    // the same edge where the following stage samples them
    always_ff @(posedge clk)
    begin
        if (word_valid)
        begin
            state_q  <= round_out;
            window_q <= {window_q[`SHA_BLOCK_WORDS-2:0], word};
        end
    end

    assign state_out  = state_q;
    assign window_out = window_q;

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    )
    else $error("Intake done held for more than one cycle");

endmodule

// File: hw/expand_stage.sv
`timescale 1ns/1ps

`include "sha256_defines.svh"

module expand_stage import sha256_types_pkg::*, sha256_algo_pkg::*;
#(
    parameter int unsigned STAGE_INDEX = 1
)
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  state_t  state_in,
    input  window_t window_in,
    output logic    done,
    output state_t  state_out,
    output window_t window_out
);

    logic       busy;
    logic       last_round;
    round_cnt_t cnt;
    state_t     state_q;
    state_t     round_out;
    word_t      w_next;
    word_t      k;
    window_t    window;

    assign last_round = busy && (cnt == round_cnt_t'(`SHA_STAGE_ROUNDS - 1));
    assign k          = round_k(STAGE_INDEX, cnt);

    // The last round uses w_next directly, the window itself is not shifted then
    msg_schedule sched_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (in_valid),
        .window_in (window_in),
        .advance   (busy && !last_round),
        .w_next    (w_next),
        .window    (window)
    );

    sha256_round round_i (
        .state      (state_q),
        .w          (w_next),
        .k          (k),
        .next_state (round_out)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= last_round;
            if (in_valid)
            begin
                busy <= 1'b1; // A new block may follow directly on the last round
                cnt  <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + round_cnt_t'(1);
                if (last_round)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
            state_q <= state_in;
        else if (busy)
            state_q <= round_out;

        // Result goes to its own registers so the working state is free at once
        if (last_round)
        begin
            state_out  <= round_out;
            window_out <= {window[`SHA_BLOCK_WORDS-2:0], w_next};
        end
    end

    // The previous stage needs at least 16 cycles per block, so a new block can
    // only land on the last round of the current one
    no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> (!busy || last_round)
    )
    else $error("Stage %0d received a block while still busy", STAGE_INDEX);

endmodule

// File: hw/digest_finalize.sv
`timescale 1ns/1ps

`include "sha256_defines.svh"

module digest_finalize import sha256_types_pkg::*, sha256_algo_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  state_t state_in,
    output state_t digest,
    output logic   digest_valid
);

    localparam int STATE_WORDS = $bits(state_t) / `SHA_WORD_W;

    state_t digest_sum;

    // Word by word addition, carries stay inside each word
    always_comb
    begin
        for (int i = 0; i < STATE_WORDS; i++)
        begin
            digest_sum[i] = state_in[i] + H_INIT[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            digest       <= '0;
            digest_valid <= 1'b0;
        end
        else
        begin
            digest_valid <= in_valid; // One cycle, like the pulse that fed it
            if (in_valid)
                digest <= digest_sum;
        end
    end

endmodule

// File: hw/sha256_pipe_top.sv
`timescale 1ns/1ps

module sha256_pipe_top import sha256_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   word_valid,
    input  word_t  word,
    output state_t digest,
    output logic   digest_valid
);

    // Stage 0 is the intake, stages 1 to 3 expand the schedule
    logic    st0_done;
    logic    st1_done;
    logic    st2_done;
    logic    st3_done;
    state_t  st0_state;
    state_t  st1_state;
    state_t  st2_state;
    state_t  st3_state;
    window_t st0_window;
    window_t st1_window;
    window_t st2_window;

    intake_stage intake_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word       (word),
        .done       (st0_done),
        .state_out  (st0_state),
        .window_out (st0_window)
    );

    expand_stage #(.STAGE_INDEX(1)) expand1_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (st0_done),
        .state_in   (st0_state),
        .window_in  (st0_window),
        .done       (st1_done),
        .state_out  (st1_state),
        .window_out (st1_window)
    );

    expand_stage #(.STAGE_INDEX(2)) expand2_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (st1_done),
        .state_in   (st1_state),
        .window_in  (st1_window),
        .done       (st2_done),
        .state_out  (st2_state),
        .window_out (st2_window)
    );

    expand_stage #(.STAGE_INDEX(3)) expand3_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (st2_done),
        .state_in   (st2_state),
        .window_in  (st2_window),
        .done       (st3_done),
        .state_out  (st3_state),
        .window_out ()
    );

    digest_finalize finalize_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (st3_done),
        .state_in     (st3_state),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

endmodule

// File: dv/tb_sha256.sv
`timescale 1ns/1ps

`include "sha256_defines.svh"

module tb_sha256 import sha256_types_pkg::*;
();

    localparam int NUM_VECTORS = 4;
    localparam int DIGEST_WORDS = 8;
    localparam int LINE_WORDS = `SHA_BLOCK_WORDS + DIGEST_WORDS;
    localparam int WAIT_LIMIT = 100;
    localparam int VAL_W = $bits(state_t);

    // Word 15 is sampled one edge after it is driven, then three expand stages
    // of 17 edges each and one edge in the finalizer
    localparam int WORD15_TO_DIGEST = 53;

    logic   clk;
    logic   rst_n;
    logic   word_valid;
    word_t  word;
    state_t digest;
    logic   digest_valid;

    logic [`SHA_WORD_W-1:0] vec_mem [0:NUM_VECTORS*LINE_WORDS-1];

    state_t      exp_digest_q[$];
    int          exp_cycle_q[$];
    int          cycle = 0;
    int          pulse_count = 0;
    int          sent_count;
    logic [31:0] lfsr_state;

    sha256_pipe_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_valid   (word_valid),
        .word         (word),
        .digest       (digest),
        .digest_valid (digest_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1; // Holds the number of the last rising edge

    task automatic abort_run;
        $display("sim failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input logic [VAL_W-1:0] got, input logic [VAL_W-1:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (rst_n && digest_valid)
        begin
            if (exp_digest_q.size() == 0)
            begin
                $display("A digest_valid pulse came at %0t ns with no block pending", $time);
                abort_run();
            end
            else
            begin
                check_value(digest, exp_digest_q.pop_front(), "digest");
                check_value(VAL_W'(cycle), VAL_W'(exp_cycle_q.pop_front()), "digest latency");
                pulse_count++;
            end
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_bits(input int n, output int unsigned value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic state_t expected_digest(input int v);
        state_t d;
        for (int i = 0; i < DIGEST_WORDS; i++)
        begin
            d[i] = vec_mem[v*LINE_WORDS + `SHA_BLOCK_WORDS + i];
        end
        return d;
    endfunction

    task automatic apply_reset;
        rst_n      = 1'b0;
        word_valid = 1'b0;
        word       = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic drive_idle;
        @(posedge clk);
        #2;
        word_valid = 1'b0;
        word       = 32'hdead_beef; // Must be ignored while the strobe is low
    endtask

    task automatic send_word(input word_t value);
        @(posedge clk);
        #2;
        word_valid = 1'b1;
        word       = value;
    endtask

    // Leaves the strobe high after the last word so blocks can follow directly
    task automatic send_block(input int v, input bit with_gaps);
        int unsigned gap;
        for (int i = 0; i < `SHA_BLOCK_WORDS; i++)
        begin
            if (with_gaps)
            begin
                take_random_bits(2, gap);
                repeat (gap) drive_idle();
            end
            send_word(vec_mem[v*LINE_WORDS + i]);
        end
        exp_digest_q.push_back(expected_digest(v));
        exp_cycle_q.push_back(cycle + WORD15_TO_DIGEST);
        sent_count++;
    endtask

    task automatic wait_for_pulses(input int target, input string what);
        int waited;
        waited = 0;
        while (pulse_count < target)
        begin
            if (waited >= WAIT_LIMIT)
            begin
                $display("Timed out after %0d cycles waiting for the digest of %s",
                         WAIT_LIMIT, what);
                abort_run();
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic quiet_check(input int n);
        repeat (n)
        begin
            @(negedge clk);
            check_value(VAL_W'(digest_valid), VAL_W'(0), "digest_valid while idle");
            check_value(digest, '0, "digest while idle");
        end
    endtask

    initial
    begin
        rst_n       = 1'b0;
        word_valid  = 1'b0;
        word        = '0;
        sent_count  = 0;
        lfsr_state  = 32'h961f_fbe0;

        $readmemh("dv/sha256_input_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VECTORS*LINE_WORDS-1]) ||
            vec_mem[NUM_VECTORS*LINE_WORDS-1] == '0)
        begin
            $display("Could not read the vector file dv/sha256_input_vectors.txt");
            abort_run();
        end

        apply_reset();
        quiet_check(20);

        // One block at a time
        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            send_block(v, 1'b0);
            drive_idle();
            wait_for_pulses(sent_count, "a single block");
        end

        // Back to back with up to four blocks in flight
        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            send_block(v, 1'b0);
        end
        drive_idle();
        wait_for_pulses(sent_count, "back to back blocks");

        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            send_block(v, 1'b1);
        end
        drive_idle();
        wait_for_pulses(sent_count, "blocks with idle gaps");

        // Reset in the middle of a block must drop it
        for (int i = 0; i < 7; i++)
        begin
            send_word(vec_mem[LINE_WORDS + i]);
        end
        drive_idle();
        apply_reset();
        quiet_check(90);
        send_block(2, 1'b0);
        drive_idle();
        wait_for_pulses(sent_count, "the block after reset");

        // Idle long enough for any stray digest_valid pulse to reach the monitor
        repeat (WAIT_LIMIT) @(posedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/sha256_types_pkg.sv
hw/sha256_algo_pkg.sv
hw/sha256_round.sv
hw/msg_schedule.sv
hw/intake_stage.sv
hw/expand_stage.sv
hw/digest_finalize.sv
hw/sha256_pipe_top.sv
dv/tb_sha256.sv

// File: Makefile
TOP := tb_sha256
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -o $(TOP)

# The log decides the result, the simulator's own exit status is not used
run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/sha256_input_vectors.txt
// Each row: 16 message words W0..W15 of one padded block, then 8 expected digest words H0..H7
// Rows: empty message, abc, a, hello
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018 ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
61800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 ca978112 ca1bbdca fac231b3 9a23dc4d a786eff8 147c4e72 b9807785 afee48bb
68656c6c 6f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000028 2cf24dba 5fb0a30e 26e83b2a c5b9e29e 1b161e5c 1fa7425e 73043362 938b9824
